// File: counting_filter_macros.svh
// ============================
// Counting filter sizing
// Bucket count, counter width, remove FIFO depth and pipeline depths
// ============================

`ifndef COUNTING_FILTER_MACROS_SVH
`define COUNTING_FILTER_MACROS_SVH

// Number of buckets held in the bank
`define CF_N_BUCKETS 16

// Width of each bucket counter
`define CF_BUCKET_BITS 4

// Remove requests that may wait behind inserts
`define CF_REMOVE_FIFO_DEPTH 4

// Address width of a bucket
`define CF_IDX_BITS ($clog2(`CF_N_BUCKETS))

// Read-modify-write stages, read request through the extra bypass stage
`define CF_UPD_STAGES 3

// Cycles from a test request to its result
`define CF_TEST_STAGES 2

`endif

// File: counting_filter_pkg.sv
// ============================
// Counting filter types
// Shared index, value and pointer types and the RAM clear FSM states
// ============================

`default_nettype none

`include "counting_filter_macros.svh"

package counting_filter_pkg;

    // Address of one bucket
    typedef logic [`CF_IDX_BITS-1:0] bucket_idx_t;

    // Counter value stored in a bucket
    typedef logic [`CF_BUCKET_BITS-1:0] bucket_value_t;

    // Read and write pointers of the remove FIFO
    typedef logic [$clog2(`CF_REMOVE_FIFO_DEPTH)-1:0] fifo_ptr_t;

    // States of the clearing walk that runs after reset
    typedef enum logic
    {
        init_clear,
        init_done
    } ram_init_state_t;

endpackage

`default_nettype wire

// File: counting_filter_top.sv
// ============================
// Counting filter bank top
// Remove FIFO, update pipeline and test port
// ============================

`timescale 1ns/1ps
`default_nettype none

`include "counting_filter_macros.svh"

module counting_filter_top
(
    input  wire logic                             clk,
    input  wire logic                             reset,
    output logic                                  rdy,
    input  wire counting_filter_pkg::bucket_idx_t insert,
    input  wire logic                             insert_en,
    input  wire counting_filter_pkg::bucket_idx_t remove,
    input  wire logic                             remove_en,
    output logic                                  remove_notFull,
    input  wire counting_filter_pkg::bucket_idx_t test_req,
    output counting_filter_pkg::bucket_value_t    test_value,
    output logic                                  test_is_zero
);
    import counting_filter_pkg::*;

    // FIFO head and the dequeue back from the update pipeline
    bucket_idx_t   remove_idx;
    logic          remove_not_empty;
    logic          process_remove;

    // Update RAM write, also feeding the test copy
    logic          wr_en;
    bucket_idx_t   wr_idx;
    bucket_value_t wr_val;

    // Removes wait here while inserts hold the update port
    remove_fifo
    #(
        .depth (`CF_REMOVE_FIFO_DEPTH)
    )
    u_remove_fifo
    (
        .clk       (clk),
        .reset     (reset),
        .enq_data  (remove),
        .enq_en    (remove_en),
        .not_full  (remove_notFull),
        .first     (remove_idx),
        .deq_en    (process_remove),
        .not_empty (remove_not_empty)
    );

    update_pipeline u_update_pipeline
    (
        .clk              (clk),
        .reset            (reset),
        .rdy              (rdy),
        .insert           (insert),
        .insert_en        (insert_en),
        .remove_idx       (remove_idx),
        .remove_not_empty (remove_not_empty),
        .process_remove   (process_remove),
        .wr_en            (wr_en),
        .wr_idx           (wr_idx),
        .wr_val           (wr_val)
    );

    test_value_port u_test_value_port
    (
        .clk          (clk),
        .reset        (reset),
        .test_req     (test_req),
        .wr_en        (wr_en),
        .wr_idx       (wr_idx),
        .wr_val       (wr_val),
        .test_value   (test_value),
        .test_is_zero (test_is_zero)
    );

endmodule

`default_nettype wire

// File: filter_checker.sv
// ============================
// Counting filter checker
// Models every bucket and compares each test result and the FIFO flag
// ============================

`timescale 1ns/1ps
`default_nettype none

`include "counting_filter_macros.svh"

module filter_checker
(
    input  wire logic                               clk,
    input  wire logic                               reset,
    input  wire logic                               rdy,
    input  wire counting_filter_pkg::bucket_idx_t   insert,
    input  wire logic                               insert_en,
    input  wire counting_filter_pkg::bucket_idx_t   remove,
    input  wire logic                               remove_en,
    input  wire logic                               remove_notFull,
    input  wire counting_filter_pkg::bucket_idx_t   test_req,
    input  wire counting_filter_pkg::bucket_value_t test_value,
    input  wire logic                               test_is_zero,
    input  wire logic                               table_check_en,
    input  wire counting_filter_pkg::bucket_value_t table_check_value,
    output int                                      mismatch_count,
    output int                                      test_count
);
    import counting_filter_pkg::*;

    // Reference count of every bucket, updated when an operation takes effect
    int            counts [0:`CF_N_BUCKETS-1];

    // Removes waiting behind inserts, mirroring the DUT's FIFO
    bucket_idx_t   remove_q [$];
    bucket_idx_t   head;

    // Clear walk length seen after reset
    int            init_cycles;
    logic          rdy_seen;

    // Expected results of the requests one and two cycles back
    logic          exp_valid [1:2];
    bucket_value_t exp_value [1:2];
    logic          tbl_en [1:2];
    bucket_value_t tbl_value [1:2];

    task automatic report_mismatch(input string what, input int got, input int want);
        mismatch_count++;
        $display("mismatch at %0t ns: %s is %0d, expected %0d", $time, what, got, want);
    endtask

    // Everything is sampled on the rising edge, before the DUT's flops move
    always @(posedge clk)
    begin
        if (reset)
        begin
            for (int b = 0; b < `CF_N_BUCKETS; b++)
            begin
                counts[b] = 0;
            end
            remove_q.delete();
            init_cycles = 0;
            rdy_seen = 1'b0;
            exp_valid[1] = 1'b0;
            exp_valid[2] = 1'b0;
        end
        else
        begin
            // The clear walk takes one cycle per bucket
            if (rdy !== 1'b1)
            begin
                init_cycles++;
                if (rdy_seen)
                begin
                    report_mismatch("rdy after the clear walk", 0, 1);
                end
            end
            else if (!rdy_seen)
            begin
                rdy_seen = 1'b1;
                if (init_cycles != `CF_N_BUCKETS)
                begin
                    report_mismatch("clear walk length", init_cycles, `CF_N_BUCKETS);
                end
            end

            // Result of the request made two cycles ago
            if (exp_valid[2])
            begin
                test_count++;
                if (test_value !== exp_value[2])
                begin
                    report_mismatch("test_value", test_value, exp_value[2]);
                end
                if (test_is_zero !== (exp_value[2] == '0))
                begin
                    report_mismatch("test_is_zero", test_is_zero, exp_value[2] == '0);
                end
                if (tbl_en[2] && (test_value !== tbl_value[2]))
                begin
                    report_mismatch("test_value against table", test_value, tbl_value[2]);
                end
            end

            // The FIFO is full once depth removes are waiting
            if (remove_notFull !== (remove_q.size() < `CF_REMOVE_FIFO_DEPTH))
            begin
                report_mismatch("remove_notFull", remove_notFull,
                                remove_q.size() < `CF_REMOVE_FIFO_DEPTH);
            end

            exp_valid[2] = exp_valid[1];
            exp_value[2] = exp_value[1];
            tbl_en[2] = tbl_en[1];
            tbl_value[2] = tbl_value[1];

            // A request sees every operation taken before its own cycle
            exp_valid[1] = (rdy === 1'b1);
            exp_value[1] = bucket_value_t'(counts[test_req]);
            tbl_en[1] = table_check_en;
            tbl_value[1] = table_check_value;

            // The head leaves only in a cycle that has no insert
            if (!insert_en && (remove_q.size() != 0))
            begin
                head = remove_q.pop_front();
                counts[head]--;
            end
            // A new remove reaches the head one cycle later
            if (remove_en && remove_notFull)
            begin
                remove_q.push_back(remove);
            end
            if (insert_en)
            begin
                counts[insert]++;
            end
        end
    end

endmodule

`default_nettype wire

// File: filter_ram_init.sv
// ============================
// Self-clearing simple dual-port RAM
// Registered writes, two-cycle reads, zero fill after reset
// ============================

`timescale 1ns/1ps
`default_nettype none

`include "counting_filter_macros.svh"

module filter_ram_init
#(
    parameter int n_data_bits = `CF_BUCKET_BITS
)
(
    input  wire logic                         clk,
    input  wire logic                         reset,
    output logic                              rdy,
    input  wire counting_filter_pkg::bucket_idx_t raddr,
    output logic [n_data_bits-1:0]            rdata,
    input  wire counting_filter_pkg::bucket_idx_t waddr,
    input  wire logic                         wen,
    input  wire logic [n_data_bits-1:0]       wdata
);
    import counting_filter_pkg::*;

    logic [n_data_bits-1:0] mem [0:`CF_N_BUCKETS-1];

    ram_init_state_t        init_state;
    bucket_idx_t            init_addr;

    // Read address register, the first of the two read cycles
    bucket_idx_t            raddr_q;

    // Write port register
    logic                   wen_q;
    bucket_idx_t            waddr_q;
    logic [n_data_bits-1:0] wdata_q;

    assign rdy = (init_state == init_done);

    // Walk every address once after reset, then stay done
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            init_state <= init_clear;
            init_addr <= '0;
        end
        else if (init_state == init_clear)
        begin
            init_addr <= init_addr + 1'b1;
            if (init_addr == bucket_idx_t'(`CF_N_BUCKETS - 1))
            begin
                init_state <= init_done;
            end
        end
    end

    // Writes arriving while the walk is still running are dropped
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wen_q <= 1'b0;
        end
        else
        begin
            wen_q <= wen && rdy;
        end
        waddr_q <= waddr;
        wdata_q <= wdata;
    end

    // The clear owns the array until it finishes
    always_ff @(posedge clk)
    begin
        if (init_state == init_clear)
        begin
            mem[init_addr] <= '0;
        end
        else if (wen_q)
        begin
            mem[waddr_q] <= wdata_q;
        end
    end

    // Address flop, then array read into the output register
    always_ff @(posedge clk)
    begin
        raddr_q <= raddr;
        rdata <= mem[raddr_q];
    end

endmodule

`default_nettype wire

// File: remove_fifo.sv
// ============================
// Remove request FIFO
// Circular buffer whose head is held in a register
// ============================

`timescale 1ns/1ps
`default_nettype none

`include "counting_filter_macros.svh"

module remove_fifo
#(
    parameter int depth = `CF_REMOVE_FIFO_DEPTH
)
(
    input  wire logic                             clk,
    input  wire logic                             reset,
    input  wire counting_filter_pkg::bucket_idx_t enq_data,
    input  wire logic                             enq_en,
    output logic                                  not_full,
    output counting_filter_pkg::bucket_idx_t      first,
    input  wire logic                             deq_en,
    output logic                                  not_empty
);
    import counting_filter_pkg::*;

    // Occupancy must reach depth itself, so it needs one more value than a pointer
    typedef logic [$clog2(depth+1)-1:0] fifo_count_t;

    bucket_idx_t mem [0:depth-1];

    fifo_ptr_t   wr_ptr;
    fifo_ptr_t   rd_ptr;
    fifo_ptr_t   rd_ptr_next;
    fifo_count_t count;
    fifo_count_t count_after_deq;
    fifo_count_t count_next;
    logic        do_enq;
    logic        do_deq;

    // Pointers wrap at depth, which need not be a power of two
    function automatic fifo_ptr_t ptr_inc(input fifo_ptr_t ptr);
        fifo_ptr_t nxt;
        if (ptr == fifo_ptr_t'(depth - 1))
        begin
            nxt = '0;
        end
        else
        begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    assign not_full = (count < fifo_count_t'(depth));
    assign not_empty = (count != '0);

    // Guard both ends so a stray request cannot corrupt the pointers
    assign do_enq = enq_en && not_full;
    assign do_deq = deq_en && not_empty;

    assign rd_ptr_next = do_deq ? ptr_inc(rd_ptr) : rd_ptr;
    assign count_after_deq = count - fifo_count_t'(do_deq);
    assign count_next = count_after_deq + fifo_count_t'(do_enq);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (do_enq)
            begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            rd_ptr <= rd_ptr_next;
            count <= count_next;
        end
    end

    // Storage and head register. When the FIFO would otherwise be empty the
    // incoming entry goes straight to the head, so it shows up one cycle later
    always_ff @(posedge clk)
    begin
        if (do_enq)
        begin
            mem[wr_ptr] <= enq_data;
        end
        first <= (count_after_deq == '0) ? enq_data : mem[rd_ptr_next];
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+.
counting_filter_pkg.sv
filter_ram_init.sv
remove_fifo.sv
update_pipeline.sv
test_value_port.sv
counting_filter_top.sv
filter_checker.sv
tb_counting_filter.sv

// File: tb_counting_filter.sv
// ============================
// Counting filter testbench
// Table of directed rows, then a random mix of inserts, removes and tests
// ============================

`timescale 1ns/1ps
`default_nettype none

`include "counting_filter_macros.svh"

module tb_counting_filter;
    import counting_filter_pkg::*;

    localparam int clk_half_period = 20;
    localparam int reset_cycles = 8;
    localparam int max_rows = 64;
    localparam int rdy_timeout = 100;
    localparam int full_timeout = 50;
    localparam int random_cycles = 300;

    logic          clk;
    logic          reset;
    logic          rdy;
    bucket_idx_t   insert;
    logic          insert_en;
    bucket_idx_t   remove;
    logic          remove_en;
    logic          remove_notFull;
    bucket_idx_t   test_req;
    bucket_value_t test_value;
    logic          test_is_zero;

    // Expected value from the table, compared by the checker when enabled
    logic          table_check_en;
    bucket_value_t table_check_value;

    int            mismatch_count;
    int            test_count;
    int            fault_count;
    logic          timed_out;

    // Stimulus table with one applied cycle per row plus its idle cycles
    logic          row_ins_en [0:max_rows-1];
    bucket_idx_t   row_ins [0:max_rows-1];
    logic          row_rem_en [0:max_rows-1];
    bucket_idx_t   row_rem [0:max_rows-1];
    bucket_idx_t   row_test [0:max_rows-1];
    int            row_idle [0:max_rows-1];
    int            row_exp [0:max_rows-1];
    int            row_count;

    // Net count per bucket as issued so the random phase stays in range
    int            shadow [0:`CF_N_BUCKETS-1];

    initial
    begin
        clk = 1'b0;
    end

    always #clk_half_period clk = ~clk;

    counting_filter_top u_counting_filter_top
    (
        .clk            (clk),
        .reset          (reset),
        .rdy            (rdy),
        .insert         (insert),
        .insert_en      (insert_en),
        .remove         (remove),
        .remove_en      (remove_en),
        .remove_notFull (remove_notFull),
        .test_req       (test_req),
        .test_value     (test_value),
        .test_is_zero   (test_is_zero)
    );

    filter_checker u_filter_checker
    (
        .clk               (clk),
        .reset             (reset),
        .rdy               (rdy),
        .insert            (insert),
        .insert_en         (insert_en),
        .remove            (remove),
        .remove_en         (remove_en),
        .remove_notFull    (remove_notFull),
        .test_req          (test_req),
        .test_value        (test_value),
        .test_is_zero      (test_is_zero),
        .table_check_en    (table_check_en),
        .table_check_value (table_check_value),
        .mismatch_count    (mismatch_count),
        .test_count        (test_count)
    );

    // Inputs change a little after the edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic finish_run();
        if (test_count == 0)
        begin
            $display("no test results were checked");
            fault_count++;
        end
        $display("errors: %0d mismatches, %0d other failures, %0d test results checked",
                 mismatch_count, fault_count, test_count);
        if ((mismatch_count == 0) && (fault_count == 0))
        begin
            $display("TEST PASS");
        end
        else
        begin
            $display("TEST FAIL");
        end
        $finish;
    endtask

    task automatic note_timeout(input string why);
        fault_count++;
        timed_out = 1'b1;
        $display("timeout at %0t ns: %s", $time, why);
    endtask

    task automatic wait_for_rdy();
        int waited;
        waited = 0;
        while ((rdy !== 1'b1) && (waited < rdy_timeout))
        begin
            next_cycle();
            waited++;
        end
        if (rdy !== 1'b1)
        begin
            note_timeout("rdy never rose after reset");
        end
    endtask

    task automatic wait_remove_space();
        int waited;
        waited = 0;
        while ((remove_notFull !== 1'b1) && (waited < full_timeout))
        begin
            next_cycle();
            waited++;
        end
        if (remove_notFull !== 1'b1)
        begin
            note_timeout("remove FIFO stayed full");
        end
    endtask

    task automatic add_row(input logic ins_en, input int ins, input logic rem_en,
                           input int rem, input int test, input int idle, input int exp);
        row_ins_en[row_count] = ins_en;
        row_ins[row_count] = bucket_idx_t'(ins);
        row_rem_en[row_count] = rem_en;
        row_rem[row_count] = bucket_idx_t'(rem);
        row_test[row_count] = bucket_idx_t'(test);
        row_idle[row_count] = idle;
        row_exp[row_count] = exp;
        row_count++;
    endtask

    // An expected value of -1 leaves the row to the checker's model alone
    task automatic build_table();
        int b;
        row_count = 0;
        // Every bucket reads zero right after the clear
        for (b = 0; b < `CF_N_BUCKETS; b++)
        begin
            add_row(0, 0, 0, 0, b, 0, 0);
        end
        // An insert shows in the test of the next cycle
        add_row(1, 3, 0, 0, 3, 0, 0);
        add_row(0, 0, 0, 0, 3, 0, 1);
        // Each back-to-back insert is tested in its own cycle and sees the count before it
        for (b = 0; b < 6; b++)
        begin
            add_row(1, 5, 0, 0, 5, 0, b);
        end
        add_row(0, 0, 0, 0, 5, 2, 6);
        // Removes with no insert traffic go straight through the FIFO
        add_row(0, 0, 1, 5, 5, 0, -1);
        add_row(0, 0, 1, 5, 5, 0, -1);
        add_row(0, 0, 1, 5, 5, 6, -1);
        add_row(0, 0, 0, 0, 5, 0, 3);
        // Eight inserts in a row hold four removes back and fill the FIFO
        for (b = 0; b < 8; b++)
        begin
            add_row(1, 9, b < 4, 9, 9, (b == 7) ? 8 : 0, -1);
        end
        add_row(0, 0, 0, 0, 9, 0, 4);
        // Insert and remove on different buckets in the same cycle
        add_row(1, 12, 1, 3, 12, 6, -1);
        add_row(0, 0, 0, 0, 3, 0, 0);
        add_row(0, 0, 0, 0, 12, 0, 1);
    endtask

    task automatic drive_op(input logic ins_en, input bucket_idx_t ins, input logic rem_en,
                            input bucket_idx_t rem, input bucket_idx_t test);
        insert_en = ins_en;
        insert = ins;
        remove_en = rem_en;
        remove = rem;
        test_req = test;
        if (ins_en)
        begin
            shadow[ins]++;
        end
        if (rem_en)
        begin
            shadow[rem]--;
        end
    endtask

    task automatic clear_ops();
        insert_en = 1'b0;
        remove_en = 1'b0;
        table_check_en = 1'b0;
    endtask

    task automatic apply_row(input int r);
        int k;
        if (row_rem_en[r])
        begin
            wait_remove_space();
        end
        if (!timed_out)
        begin
            drive_op(row_ins_en[r], row_ins[r], row_rem_en[r], row_rem[r], row_test[r]);
            table_check_en = (row_exp[r] >= 0);
            table_check_value = bucket_value_t'(row_exp[r]);
            next_cycle();
            clear_ops();
            for (k = 0; k < row_idle[r]; k++)
            begin
                next_cycle();
            end
        end
    endtask

    // Up to four removes may still wait per bucket, so inserts stop at 11
    task automatic run_random();
        int   c;
        int   b_ins;
        int   b_rem;
        logic do_ins;
        logic do_rem;
        for (c = 0; c < random_cycles; c++)
        begin
            b_ins = $urandom_range(`CF_N_BUCKETS - 1);
            b_rem = $urandom_range(`CF_N_BUCKETS - 1);
            do_ins = ($urandom_range(99) < 50) && (shadow[b_ins] < 11);
            do_rem = ($urandom_range(99) < 40) && (shadow[b_rem] > 0) &&
                     (remove_notFull === 1'b1);
            drive_op(do_ins, bucket_idx_t'(b_ins), do_rem, bucket_idx_t'(b_rem),
                     bucket_idx_t'($urandom_range(`CF_N_BUCKETS - 1)));
            next_cycle();
            clear_ops();
        end
    endtask

    initial
    begin
        void'($urandom(5554));
        reset = 1'b1;
        insert = '0;
        insert_en = 1'b0;
        remove = '0;
        remove_en = 1'b0;
        test_req = '0;
        table_check_en = 1'b0;
        table_check_value = '0;
        fault_count = 0;
        timed_out = 1'b0;
        for (int b = 0; b < `CF_N_BUCKETS; b++)
        begin
            shadow[b] = 0;
        end
        build_table();

        repeat (reset_cycles) @(posedge clk);
        #2;
        reset = 1'b0;
        wait_for_rdy();

        for (int r = 0; (r < row_count) && !timed_out; r++)
        begin
            apply_row(r);
        end
        if (!timed_out)
        begin
            run_random();
            // Let the last requests come out of the test port
            repeat (4) next_cycle();
        end
        finish_run();
    end

endmodule

`default_nettype wire

// File: test_value_port.sv
// ============================
// Test value port
// Two-cycle bucket lookup, bypassed from writes in flight
// ============================

`timescale 1ns/1ps
`default_nettype none

`include "counting_filter_macros.svh"

module test_value_port
(
    input  wire logic                               clk,
    input  wire logic                               reset,
    input  wire counting_filter_pkg::bucket_idx_t   test_req,
    input  wire logic                               wr_en,
    input  wire counting_filter_pkg::bucket_idx_t   wr_idx,
    input  wire counting_filter_pkg::bucket_value_t wr_val,
    output counting_filter_pkg::bucket_value_t      test_value,
    output logic                                    test_is_zero
);
    import counting_filter_pkg::*;

    bucket_value_t rd_val;

    // A write in the request cycle itself never reaches the RAM read in time
    logic          hit_s0;

    // Per stage: did a write hit the tracked bucket, and its newest value
    logic          byp_en [1:`CF_TEST_STAGES];
    bucket_value_t byp_val [1:`CF_TEST_STAGES];

    // Bucket tracked by each stage that still compares against writes
    bucket_idx_t   trk_idx [1:`CF_TEST_STAGES-1];

    // Private copy of the counters, written by the same broadcast as the update RAM
    filter_ram_init
    #(
        .n_data_bits (`CF_BUCKET_BITS)
    )
    u_test_ram
    (
        .clk   (clk),
        .reset (reset),
        .rdy   (),
        .raddr (test_req),
        .rdata (rd_val),
        .waddr (wr_idx),
        .wen   (wr_en),
        .wdata (wr_val)
    );

    assign hit_s0 = wr_en && (wr_idx == test_req);

    // Hit flags are control state and start clear
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int p = 1; p <= `CF_TEST_STAGES; p++)
            begin
                byp_en[p] <= 1'b0;
            end
        end
        else
        begin
            byp_en[1] <= hit_s0;
            for (int p = 2; p <= `CF_TEST_STAGES; p++)
            begin
                byp_en[p] <= byp_en[p-1] || (wr_en && (wr_idx == trk_idx[p-1]));
            end
        end
    end

    // A later write to the same bucket replaces the held value
    always_ff @(posedge clk)
    begin
        byp_val[1] <= wr_val;
        trk_idx[1] <= test_req;
        for (int p = 2; p <= `CF_TEST_STAGES; p++)
        begin
            if (wr_en && (wr_idx == trk_idx[p-1]))
            begin
                byp_val[p] <= wr_val;
            end
            else
            begin
                byp_val[p] <= byp_val[p-1];
            end
        end
        for (int p = 2; p < `CF_TEST_STAGES; p++)
        begin
            trk_idx[p] <= trk_idx[p-1];
        end
    end

    assign test_value = byp_en[`CF_TEST_STAGES] ? byp_val[`CF_TEST_STAGES] : rd_val;
    assign test_is_zero = (test_value == '0);

endmodule

`default_nettype wire

// File: update_pipeline.sv
// ============================
// Counter update pipeline
// Read-modify-write of one bucket per cycle, with in-flight bypass
// ============================

`timescale 1ns/1ps
`default_nettype none

`include "counting_filter_macros.svh"

module update_pipeline
(
    input  wire logic                             clk,
    input  wire logic                             reset,
    output logic                                  rdy,
    input  wire counting_filter_pkg::bucket_idx_t insert,
    input  wire logic                             insert_en,
    input  wire counting_filter_pkg::bucket_idx_t remove_idx,
    input  wire logic                             remove_not_empty,
    output logic                                  process_remove,
    output logic                                  wr_en,
    output counting_filter_pkg::bucket_idx_t      wr_idx,
    output counting_filter_pkg::bucket_value_t    wr_val
);
    import counting_filter_pkg::*;

    // Stage 0 is the selected operation, presented to the RAM read port
    logic          sel_en;
    bucket_idx_t   sel_idx;
    logic          sel_is_insert;

    // Registered copies of the operation. Stage 3 exists only so the delta
    // in stage 1 can still see the update that writes one cycle later
    logic          upd_en [1:`CF_UPD_STAGES];
    bucket_idx_t   upd_idx [1:`CF_UPD_STAGES];
    logic          upd_is_insert [1:`CF_UPD_STAGES];

    bucket_value_t rd_val;

    // Net change of the bucket relative to the RAM read, range -3 to +3
    logic signed [2:0] delta_s1;
    bucket_value_t     upd_delta_s1;
    bucket_value_t     upd_delta_s2;

    // +1 for an insert, -1 for a remove
    function automatic logic signed [2:0] step(input logic is_insert);
        return is_insert ? 3'sb001 : 3'sb111;
    endfunction

    // This RAM is the same size as the test copy and clears at the same rate,
    // so its rdy speaks for both
    filter_ram_init
    #(
        .n_data_bits (`CF_BUCKET_BITS)
    )
    u_update_ram
    (
        .clk   (clk),
        .reset (reset),
        .rdy   (rdy),
        .raddr (sel_idx),
        .rdata (rd_val),
        .waddr (wr_idx),
        .wen   (wr_en),
        .wdata (wr_val)
    );

    // ============================
    // Operation select
    // ============================

    // One update port, and inserts always win it
    always_comb
    begin
        process_remove = !insert_en && remove_not_empty;
        sel_en = insert_en || remove_not_empty;
        sel_idx = insert_en ? insert : remove_idx;
        sel_is_insert = insert_en;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int p = 1; p <= `CF_UPD_STAGES; p++)
            begin
                upd_en[p] <= 1'b0;
            end
        end
        else
        begin
            upd_en[1] <= sel_en;
            for (int p = 2; p <= `CF_UPD_STAGES; p++)
            begin
                upd_en[p] <= upd_en[p-1];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        upd_idx[1] <= sel_idx;
        upd_is_insert[1] <= sel_is_insert;
        for (int p = 2; p <= `CF_UPD_STAGES; p++)
        begin
            upd_idx[p] <= upd_idx[p-1];
            upd_is_insert[p] <= upd_is_insert[p-1];
        end
    end

    // ============================
    // Bypass delta
    // ============================

    // The RAM read misses the two updates just ahead of this one, so their
    // steps are added to this operation's own step. Older ones are in memory
    always_comb
    begin
        delta_s1 = '0;
        if (upd_en[1])
        begin
            delta_s1 = step(upd_is_insert[1]);
        end
        for (int p = 2; p <= `CF_UPD_STAGES; p++)
        begin
            if (upd_en[p] && (upd_idx[p] == upd_idx[1]))
            begin
                delta_s1 = delta_s1 + step(upd_is_insert[p]);
            end
        end
        // Sign extension to the counter width
        upd_delta_s1 = bucket_value_t'(delta_s1);
    end

    always_ff @(posedge clk)
    begin
        upd_delta_s2 <= upd_delta_s1;
    end

    // Stage 2 write, broadcast to every counter copy
    assign wr_en = upd_en[2];
    assign wr_idx = upd_idx[2];
    assign wr_val = rd_val + upd_delta_s2;

endmodule

`default_nettype wire
